// ==== bench/bch_checker.sv ====
// output monitor of the BCH decoder bench, rebuilds frames and compares them with the trace
`timescale 1ns/100ps
`default_nettype none

`include "bch_consts.svh"

module bch_checker (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      iclkena,
  input  logic                      oval,
  input  bch_stream_pkg::out_beat_t out_beat,
  input  logic                      armed          // first frame fully sent
);

  // expected frames, in input order
  int                id_q[$];
  logic [`BCH_N-1:0] dat_q[$];
  logic              fail_q[$];
  logic              chk_q[$];                      // data compare enabled

  int                pass_cnt  = 0;
  int                fail_cnt  = 0;
  int                other_cnt = 0;                 // framing and stray beats
  int                done_cnt  = 0;

  logic [`BCH_N-1:0] got;
  int                nbits;
  logic              in_frame = 1'b0;
  logic              bad;

  task automatic push_expected(input int id, input logic [`BCH_N-1:0] dat,
                               input logic fail, input logic chk);
    id_q.push_back(id);
    dat_q.push_back(dat);
    fail_q.push_back(fail);
    chk_q.push_back(chk);
  endtask

  //----------------------------------------------------------------------
  // frame end, compare and report one line
  //----------------------------------------------------------------------

  task automatic close_frame(input logic fail_bit);
    int                id;
    logic [`BCH_N-1:0] ed;
    logic              ef;
    logic              ec;
    if (id_q.size() == 0) begin
      $display("output frame arrived with no expected frame left");
      other_cnt++;
    end else begin
      id = id_q.pop_front();
      ed = dat_q.pop_front();
      ef = fail_q.pop_front();
      ec = chk_q.pop_front();
      if (ec && got !== ed) begin
        $display("[ERROR] test %0d out_beat.dat expected %h got %h", id, ed, got);
        bad = 1'b1;
      end
      if (fail_bit !== ef) begin
        $display("[ERROR] test %0d out_beat.fail expected %h got %h", id, ef, fail_bit);
        bad = 1'b1;
      end
      if (bad) begin
        fail_cnt++;
        $display("test %0d failed", id);
      end else begin
        pass_cnt++;
        $display("test %0d ok, word %h fail %0d", id, got, fail_bit);
      end
    end
    done_cnt++;
  endtask

  //----------------------------------------------------------------------
  // beat collection, only enabled cycles carry a beat
  //----------------------------------------------------------------------

  always @(posedge iclk) begin
    if (!ireset && iclkena && oval) begin
      if (!armed) begin
        $display("oval went high before the first frame was received");
        other_cnt++;
      end
      if (out_beat.sop) begin
        if (in_frame) begin
          $display("sop arrived after %0d bits of an unfinished frame", nbits);
          other_cnt++;
        end
        in_frame = 1'b1;
        nbits    = 0;
        got      = '0;
        bad      = 1'b0;
      end else if (!in_frame) begin
        $display("output beat without a leading sop");
        other_cnt++;
      end
      if (in_frame) begin
        got = {got[`BCH_N-2:0], out_beat.dat};      // msb arrives first
        nbits++;
        if (out_beat.eop || nbits == `BCH_N) begin
          if (!out_beat.eop) begin
            $display("no eop on bit %0d of the frame", nbits);
            bad = 1'b1;
          end else if (nbits != `BCH_N) begin
            $display("eop after %0d bits instead of %0d", nbits, `BCH_N);
            bad = 1'b1;
          end
          close_frame(out_beat.fail);
          in_frame = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/bch_trace.txt ====
# columns: test id, received word (hex, msb first on the wire), expected word (hex),
# expected fail flag, mode bits (1 compare data, 2 enable stalls, 4 minimum gap)
1  0000 0000 0 1
2  0537 0537 0 1
3  5647 5647 0 1
4  7fff 7fff 0 1
5  4537 0537 0 1
6  0536 0537 0 1
7  5270 5370 0 1
8  4a6f 0a6e 0 1
9  77ef 7fff 0 1
10 149e 14dc 0 1
11 4081 0000 0 1
12 69bb 29b8 0 1
13 1d5d 0f59 0 1
14 000f 0000 1 0
15 0538 0537 1 0
16 0537 0537 0 5
17 4a6f 0a6e 0 5
18 5647 5647 0 5
19 0536 0537 0 5
20 69bb 29b8 0 3
21 1d5d 0f59 0 3
22 7fff 7fff 0 3
23 000f 0000 1 2

// ==== bench/tb_bch_decoder.sv ====
// testbench top that replays the trace file through the BCH decoder and reports the verdict
`timescale 1ns/100ps
`default_nettype none

`include "bch_consts.svh"

module tb_bch_decoder;

  logic                      iclk;
  logic                      ireset;
  logic                      iclkena;
  logic                      ival;
  bch_stream_pkg::bit_beat_t in_beat;
  logic                      oval;
  bch_stream_pkg::out_beat_t out_beat;
  logic                      armed;

  // trace columns
  int                tid  [64];
  logic [`BCH_N-1:0] rx   [64];
  logic [`BCH_N-1:0] ex   [64];
  int                efail[64];
  int                mode [64];                     // 1 data, 2 stalls, 4 min gap
  int                ntests;
  logic              loaded = 1'b0;
  logic              ok;
  int                seed;

  tb_clock_gen clkgen0 (.iclk(iclk), .ireset(ireset));

  bch_decoder_top dut0 (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .ival     (ival),
    .in_beat  (in_beat),
    .oval     (oval),
    .out_beat (out_beat)
  );

  bch_checker checker0 (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .oval     (oval),
    .out_beat (out_beat),
    .armed    (armed)
  );

  //----------------------------------------------------------------------
  // trace reading
  //----------------------------------------------------------------------

  task automatic load_trace(output logic good);
    int    fd;
    int    n;
    string line;
    fd     = $fopen("bench/bch_trace.txt", "r");
    ntests = 0;
    good   = (fd != 0);
    if (good) begin
      while (!$feof(fd) && ntests < 64) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin   // skip header lines
          n = $sscanf(line, "%d %h %h %d %d", tid[ntests], rx[ntests], ex[ntests],
                      efail[ntests], mode[ntests]);
          if (n == 5)
            ntests++;
        end
      end
      $fclose(fd);
    end
  endtask

  //----------------------------------------------------------------------
  // inputs change on the falling edge only
  //----------------------------------------------------------------------

  task automatic maybe_stall(inout int budget);
    if (budget > 0 && (($random(seed) & 7) == 0)) begin
      @(negedge iclk);
      iclkena = 1'b0;                               // whole pipeline frozen
      budget--;
    end
  endtask

  task automatic send_frame(input logic [`BCH_N-1:0] w, input logic stalls, input int gap);
    int budget;
    budget = stalls ? 4 : 0;
    for (int i = `BCH_N-1; i >= 0; i--) begin
      maybe_stall(budget);
      @(negedge iclk);
      iclkena     = 1'b1;
      ival        = 1'b1;
      in_beat.sop = (i == `BCH_N-1);
      in_beat.eop = (i == 0);
      in_beat.dat = w[i];
    end
    armed = 1'b1;
    for (int g = 0; g < gap; g++) begin            // idle beats while the output drains
      maybe_stall(budget);
      @(negedge iclk);
      iclkena = 1'b1;
      ival    = 1'b0;
      in_beat = '0;
    end
  endtask

  initial begin
    int gap;
    iclkena = 1'b1;
    ival    = 1'b0;
    in_beat = '0;
    armed   = 1'b0;
    seed    = 32'h875a_7a8a;
    load_trace(ok);
    if (!ok || ntests == 0) begin
      $display("trace file bench/bch_trace.txt missing or empty");
      $display("RESULT: FAIL");
      $finish;
    end else begin
      loaded = 1'b1;
      #1;
      wait (ireset === 1'b0);
      repeat (3) @(negedge iclk);
      for (int t = 0; t < ntests; t++) begin
        if ((mode[t] & 4) != 0)
          gap = `BCH_N;                             // minimum spacing
        else
          gap = `BCH_N + ($random(seed) & 7);
        checker0.push_expected(tid[t], ex[t], efail[t][0], mode[t][0]);
        send_frame(rx[t], mode[t][1], gap);
      end
      wait (checker0.done_cnt == ntests);
      repeat (4) @(posedge iclk);
      $display("tests passed %0d, failed %0d, other errors %0d",
               checker0.pass_cnt, checker0.fail_cnt, checker0.other_cnt);
      if (checker0.pass_cnt == ntests && checker0.fail_cnt == 0 && checker0.other_cnt == 0)
        $display("RESULT: PASS");
      else
        $display("RESULT: FAIL");
      $finish;
    end
  end

  // watchdog scaled to the number of frames
  initial begin
    wait (loaded);
    repeat (ntests * 40 + 100) @(posedge iclk);
    $display("timeout, decoder output did not complete in %0d cycles", ntests * 40 + 100);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
// testbench clock and power-on reset source for the BCH decoder bench
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic iclk,
  output logic ireset
);

  initial begin
    iclk = 1'b0;
    forever #4 iclk = ~iclk;                        // 8 ns period
  end

  initial begin
    ireset = 1'b1;
    repeat (5) @(posedge iclk);                     // five cycles in reset
    @(negedge iclk);
    ireset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== logic/bch_berlekamp.sv ====
// binary Berlekamp-Massey solver, turns six syndromes into the error locator
`timescale 1ns/100ps
`default_nettype none

`include "bch_consts.svh"

module bch_berlekamp (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     iclkena,
  input  logic                     syn_val,
  input  bch_stream_pkg::syn_vec_t syn,
  input  bch_stream_pkg::ptr_t     syn_ptr,
  output logic                     loc_val,
  output bch_stream_pkg::locator_t loc,
  output bch_stream_pkg::ptr_t     loc_ptr
);

  bch_stream_pkg::bm_state_e  state;
  bch_stream_pkg::syn_vec_t   s_reg;                // latched syndromes
  gf_pkg::gf_t [`BCH_T:0]     c;                    // current locator
  gf_pkg::gf_t [`BCH_T:0]     dpoly;                // x^m * B / b, pre-shifted
  gf_pkg::gf_t                d_comb;
  gf_pkg::gf_t                d_reg;                // held discrepancy
  gf_pkg::gf_t                d_inv;
  logic [1:0]                 r;                    // iteration, handles S_{2r+1}
  logic [2:0]                 len;                  // register length L, may pass t
  logic                       grow;

  //----------------------------------------------------------------------
  // discrepancy, sum of c_j * S_{2r+1-j}
  //----------------------------------------------------------------------

  always_comb begin
    int k;
    d_comb = '0;
    for (int j = 0; j <= `BCH_T; j++) begin
      k = 2 * int'(r) + 1 - j;
      if (k >= 1)
        d_comb ^= gf_pkg::gf_mul(c[j], s_reg[k]);
    end
  end

  assign d_inv = gf_pkg::gf_inv(d_reg);
  assign grow  = (d_reg != '0) && (len <= {1'b0, r});   // 2L <= 2r

  //----------------------------------------------------------------------
  // control
  //----------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state   <= bch_stream_pkg::bm_idle;
      loc_val <= 1'b0;
      loc_ptr <= '0;
      r       <= '0;
      len     <= '0;
    end else if (iclkena) begin
      loc_val <= 1'b0;
      case (state)
        bch_stream_pkg::bm_idle : begin
          if (syn_val) begin
            loc_ptr <= syn_ptr;
            r       <= '0;
            len     <= '0;
            state   <= bch_stream_pkg::bm_discrepancy;
          end
        end
        bch_stream_pkg::bm_discrepancy : begin
          state <= bch_stream_pkg::bm_update;
        end
        bch_stream_pkg::bm_update : begin
          if (grow)
            len <= {r, 1'b1} - len;                 // L = 2r + 1 - L
          if (r == 2'(`BCH_T - 1)) begin
            loc_val <= 1'b1;                        // 2t+1 cycles after syn_val
            state   <= bch_stream_pkg::bm_idle;
          end else begin
            r     <= r + 1'b1;
            state <= bch_stream_pkg::bm_discrepancy;
          end
        end
        default : state <= bch_stream_pkg::bm_idle;
      endcase
    end
  end

  //----------------------------------------------------------------------
  // polynomial datapath
  //----------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      case (state)
        bch_stream_pkg::bm_idle : begin
          if (syn_val) begin
            s_reg    <= syn;
            c        <= '0;
            c[0]     <= 1;                          // sigma = 1
            dpoly    <= '0;
            dpoly[1] <= 1;                          // x * B, B = 1
          end
        end
        bch_stream_pkg::bm_discrepancy : begin
          d_reg <= d_comb;
        end
        bch_stream_pkg::bm_update : begin
          for (int j = 0; j <= `BCH_T; j++)
            c[j] <= c[j] ^ gf_pkg::gf_mul(d_reg, dpoly[j]);
          // skipped even step folds into the x^2 shift
          dpoly[1:0] <= '0;
          for (int j = 2; j <= `BCH_T; j++)
            dpoly[j] <= grow ? gf_pkg::gf_mul(c[j-2], d_inv) : dpoly[j-2];
        end
        default : ;
      endcase
    end
  end

  //----------------------------------------------------------------------
  // result, L beyond t means uncorrectable
  //----------------------------------------------------------------------

  // zero locator makes every position a root, so Chien always flags it
  always_comb begin
    if (len > 3'(`BCH_T)) begin
      loc.deg  = 2'(`BCH_T);
      loc.coef = '0;
    end else begin
      loc.deg  = len[1:0];
      loc.coef = c;
    end
  end

endmodule

`default_nettype wire

// ==== logic/bch_chien_correct.sv ====
// Chien root search over the buffered frame, flips error bits and streams the word out
`timescale 1ns/100ps
`default_nettype none

`include "bch_consts.svh"

module bch_chien_correct (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      iclkena,
  input  logic                      loc_val,
  input  bch_stream_pkg::locator_t  loc,
  input  bch_stream_pkg::ptr_t      loc_ptr,
  output bch_stream_pkg::ptr_t      rd_ptr,
  output bch_stream_pkg::addr_t     rd_addr,
  input  logic                      rd_dat,
  output logic                      oval,
  output bch_stream_pkg::out_beat_t out_beat
);

  gf_pkg::gf_rom_t              alpha_to;
  bch_stream_pkg::chien_state_e state;
  gf_pkg::gf_t [`BCH_T:0]       term;               // sigma_j * alpha^(j*step)
  gf_pkg::gf_t                  sum;
  logic                         root;
  logic [1:0]                   deg_reg;
  logic [3:0]                   root_cnt;           // up to n roots
  logic                         last;
  logic                         start;

  // holding slot for a locator that lands mid search
  logic                         pend;
  bch_stream_pkg::locator_t     pend_loc;
  bch_stream_pkg::ptr_t         pend_ptr;
  bch_stream_pkg::locator_t     sel_loc;
  bch_stream_pkg::ptr_t         sel_ptr;

  // read stage, aligned with rd_dat
  logic s1_val, s1_sop, s1_eop, s1_root, s1_fail;

  assign alpha_to = gf_pkg::gf_alpha_to(`BCH_IRRPOL);

  //----------------------------------------------------------------------
  // evaluation, position p = 14 - rd_addr tests sigma(alpha^-p)
  //----------------------------------------------------------------------

  always_comb begin
    sum = '0;
    for (int j = 0; j <= `BCH_T; j++)
      sum ^= term[j];
  end

  assign root    = (sum == '0);
  assign last    = (state == bch_stream_pkg::chien_search) &&
                   (rd_addr == 4'(`BCH_N - 1));
  assign sel_loc = pend ? pend_loc : loc;
  assign sel_ptr = pend ? pend_ptr : loc_ptr;
  // load when idle or on the final step, so frames run back to back
  assign start   = ((state == bch_stream_pkg::chien_idle) || last) && (pend || loc_val);

  //----------------------------------------------------------------------
  // control
  //----------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state   <= bch_stream_pkg::chien_idle;
      pend    <= 1'b0;
      rd_ptr  <= '0;
      rd_addr <= '0;
      s1_val  <= 1'b0;
      oval    <= 1'b0;
    end else if (iclkena) begin
      pend <= start ? (pend & loc_val) : (pend | loc_val);
      if (start) begin
        state   <= bch_stream_pkg::chien_search;
        rd_ptr  <= sel_ptr;
        rd_addr <= '0;
      end else if (last) begin
        state <= bch_stream_pkg::chien_idle;
      end else if (state == bch_stream_pkg::chien_search) begin
        rd_addr <= rd_addr + 1'b1;
      end
      s1_val <= (state == bch_stream_pkg::chien_search);
      oval   <= s1_val;
    end
  end

  //----------------------------------------------------------------------
  // terms, root count, output beat
  //----------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (loc_val) begin
        pend_loc <= loc;
        pend_ptr <= loc_ptr;
      end
      if (start) begin
        for (int j = 0; j <= `BCH_T; j++)
          term[j] <= gf_pkg::gf_mul(sel_loc.coef[j], alpha_to[j]);
        deg_reg  <= sel_loc.deg;
        root_cnt <= '0;
      end else if (state == bch_stream_pkg::chien_search) begin
        for (int j = 0; j <= `BCH_T; j++)
          term[j] <= gf_pkg::gf_mul(term[j], alpha_to[j]);   // next position
        root_cnt <= root_cnt + root;
      end
      s1_sop  <= (rd_addr == '0);
      s1_eop  <= last;
      s1_root <= root;
      s1_fail <= ((root_cnt + root) != {2'b00, deg_reg});    // roots vs L
      out_beat.sop  <= s1_val & s1_sop;
      out_beat.eop  <= s1_val & s1_eop;
      out_beat.dat  <= rd_dat ^ s1_root;            // flip at error position
      out_beat.fail <= s1_val & s1_eop & s1_fail;
    end
  end

endmodule

`default_nettype wire

// ==== logic/bch_consts.svh ====
// code constants for the (15,5) binary BCH decoder, included by packages and RTL
`ifndef BCH_CONSTS_SVH
`define BCH_CONSTS_SVH

//----------------------------------------------------------------------
// code geometry
//----------------------------------------------------------------------

`define BCH_M       4     // bits per field element
`define BCH_N       15    // codeword length, 2^m - 1
`define BCH_K       5     // information bits
`define BCH_T       3     // correctable errors
`define BCH_T2      6     // syndromes S1..S2t

// field polynomial x^4 + x + 1
`define BCH_IRRPOL  19

//----------------------------------------------------------------------
// frame storage
//----------------------------------------------------------------------

`define BCH_BANKS   4     // frames that may sit in the buffer at once

`endif

// ==== logic/bch_decoder_top.sv ====
// top of the (15,5) BCH decoder, wires syndrome, buffer, BM and Chien stages together
`timescale 1ns/100ps
`default_nettype none

module bch_decoder_top (
  input  logic                      iclk,
  input  logic                      ireset,
  input  logic                      iclkena,
  input  logic                      ival,
  input  bch_stream_pkg::bit_beat_t in_beat,
  output logic                      oval,
  output bch_stream_pkg::out_beat_t out_beat
);

  //----------------------------------------------------------------------
  // stage links
  //----------------------------------------------------------------------

  logic                     wr_en;
  bch_stream_pkg::ptr_t     wr_ptr;
  bch_stream_pkg::addr_t    wr_addr;
  logic                     wr_dat;
  logic                     syn_val;
  bch_stream_pkg::ptr_t     syn_ptr;
  bch_stream_pkg::syn_vec_t syn;
  logic                     loc_val;
  bch_stream_pkg::locator_t loc;
  bch_stream_pkg::ptr_t     loc_ptr;
  bch_stream_pkg::ptr_t     rd_ptr;
  bch_stream_pkg::addr_t    rd_addr;
  logic                     rd_dat;

  bch_syndrome_count syndrome0 (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ival    (ival),
    .in_beat (in_beat),
    .wr_en   (wr_en),
    .wr_ptr  (wr_ptr),
    .wr_addr (wr_addr),
    .wr_dat  (wr_dat),
    .syn_val (syn_val),
    .syn_ptr (syn_ptr),
    .syn     (syn)
  );

  bch_frame_buffer buffer0 (
    .iclk    (iclk),
    .iclkena (iclkena),
    .wr_en   (wr_en),
    .wr_ptr  (wr_ptr),
    .wr_addr (wr_addr),
    .wr_dat  (wr_dat),
    .rd_ptr  (rd_ptr),
    .rd_addr (rd_addr),
    .rd_dat  (rd_dat)
  );

  bch_berlekamp berlekamp0 (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .syn_val (syn_val),
    .syn     (syn),
    .syn_ptr (syn_ptr),
    .loc_val (loc_val),
    .loc     (loc),
    .loc_ptr (loc_ptr)
  );

  bch_chien_correct chien0 (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .loc_val  (loc_val),
    .loc      (loc),
    .loc_ptr  (loc_ptr),
    .rd_ptr   (rd_ptr),
    .rd_addr  (rd_addr),
    .rd_dat   (rd_dat),
    .oval     (oval),
    .out_beat (out_beat)
  );

endmodule

`default_nettype wire

// ==== logic/bch_frame_buffer.sv ====
// banked bit RAM that keeps received frames until the Chien stage reads them back
`timescale 1ns/100ps
`default_nettype none

`include "bch_consts.svh"

module bch_frame_buffer (
  input  logic                  iclk,
  input  logic                  iclkena,
  input  logic                  wr_en,
  input  bch_stream_pkg::ptr_t  wr_ptr,
  input  bch_stream_pkg::addr_t wr_addr,
  input  logic                  wr_dat,
  input  bch_stream_pkg::ptr_t  rd_ptr,
  input  bch_stream_pkg::addr_t rd_addr,
  output logic                  rd_dat
);

  // one frame per bank, bit index = arrival order
  logic [`BCH_N-1:0] mem [`BCH_BANKS];

  //----------------------------------------------------------------------
  // write port
  //----------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena && wr_en)
      mem[wr_ptr][wr_addr] <= wr_dat;
  end

  //----------------------------------------------------------------------
  // read port, one enabled cycle latency
  //----------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena)
      rd_dat <= mem[rd_ptr][rd_addr];
  end

endmodule

`default_nettype wire

// ==== logic/bch_stream_pkg.sv ====
// stream beats, syndrome and locator bundles and FSM states of the BCH decoder
`default_nettype none

`include "bch_consts.svh"

package bch_stream_pkg;

  //----------------------------------------------------------------------
  // stream beats
  //----------------------------------------------------------------------

  typedef struct packed {
    logic sop;
    logic eop;
    logic dat;
  } bit_beat_t;                                     // input and buffer traffic

  typedef struct packed {
    logic sop;
    logic eop;
    logic dat;
    logic fail;                                     // meaningful on eop only
  } out_beat_t;

  typedef logic [$clog2(`BCH_N)-1:0]     addr_t;    // bit index in frame
  typedef logic [$clog2(`BCH_BANKS)-1:0] ptr_t;     // buffer bank

  // S1 at index 1
  typedef gf_pkg::gf_t [`BCH_T2:1] syn_vec_t;

  typedef struct packed {
    logic [1:0]               deg;                  // register length L
    gf_pkg::gf_t [`BCH_T:0]   coef;                 // sigma_0 .. sigma_t
  } locator_t;

  typedef enum logic [1:0] {bm_idle, bm_discrepancy, bm_update} bm_state_e;
  typedef enum logic {chien_idle, chien_search} chien_state_e;

endpackage

`default_nettype wire

// ==== logic/bch_syndrome_count.sv ====
// Horner syndrome accumulation with frame buffer write side, first stage of the decoder
`timescale 1ns/100ps
`default_nettype none

`include "bch_consts.svh"

module bch_syndrome_count (
  input  logic                    iclk,
  input  logic                    ireset,
  input  logic                    iclkena,
  input  logic                    ival,
  input  bch_stream_pkg::bit_beat_t in_beat,
  output logic                    wr_en,
  output bch_stream_pkg::ptr_t    wr_ptr,
  output bch_stream_pkg::addr_t   wr_addr,
  output logic                    wr_dat,
  output logic                    syn_val,
  output bch_stream_pkg::ptr_t    syn_ptr,
  output bch_stream_pkg::syn_vec_t syn
);

  gf_pkg::gf_rom_t          alpha_to;
  bch_stream_pkg::syn_vec_t acc;                    // running sums
  bch_stream_pkg::syn_vec_t syn_next;

  assign alpha_to = gf_pkg::gf_alpha_to(`BCH_IRRPOL);

  //----------------------------------------------------------------------
  // S_i = S_i * alpha^i + bit, msb first
  //----------------------------------------------------------------------

  always_comb begin
    for (int i = 1; i <= `BCH_T2; i++) begin
      syn_next[i] = {{(`BCH_M-1){1'b0}}, in_beat.dat};
      if (!in_beat.sop)                             // sop restarts the sum
        syn_next[i] ^= gf_pkg::gf_mul(acc[i], alpha_to[i]);
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      acc <= syn_next;
      if (in_beat.eop)
        syn <= syn_next;                            // held until next eop
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      syn_val <= 1'b0;
    end else if (iclkena) begin
      syn_val <= ival & in_beat.eop;                // one beat after last bit
    end
  end

  //----------------------------------------------------------------------
  // buffer write side
  //----------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_en   <= 1'b0;
      wr_ptr  <= '0;
      wr_addr <= '0;
    end else if (iclkena) begin
      wr_en <= ival;
      if (ival) begin
        wr_addr <= in_beat.sop ? '0 : wr_addr + 1'b1;
        wr_ptr  <= wr_ptr + in_beat.sop;            // new bank per frame
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && ival)
      wr_dat <= in_beat.dat;
  end

  // last bit is still being written when syn_val shows up
  assign syn_ptr = wr_ptr;

endmodule

`default_nettype wire

// ==== logic/gf_pkg.sv ====
// GF(2^m) element type and field arithmetic shared by the decoder blocks
`default_nettype none

`include "bch_consts.svh"

package gf_pkg;

  typedef logic [`BCH_M-1:0] gf_t;                  // one field element
  typedef gf_t [2**`BCH_M-1:0] gf_rom_t;            // alpha^0 .. alpha^(2^m-1)

  //----------------------------------------------------------------------
  // power table, entry i holds alpha^i
  //----------------------------------------------------------------------

  function automatic gf_rom_t gf_alpha_to(input int irrpol);
    gf_rom_t tab;
    logic [`BCH_M:0] acc;
    acc = 1;
    for (int i = 0; i < 2**`BCH_M; i++) begin
      tab[i] = acc[`BCH_M-1:0];
      acc    = acc << 1;                            // times x
      if (acc[`BCH_M])
        acc ^= irrpol[`BCH_M:0];                    // reduce
    end
    return tab;
  endfunction

  // shift and add multiply, msb of b first
  function automatic gf_t gf_mul(input gf_t a, input gf_t b);
    logic [`BCH_M:0] acc;
    gf_t p;
    p = '0;
    for (int i = `BCH_M-1; i >= 0; i--) begin
      acc = {p, 1'b0};
      if (acc[`BCH_M])
        acc ^= (`BCH_M+1)'(`BCH_IRRPOL);
      p = acc[`BCH_M-1:0] ^ (b[i] ? a : '0);
    end
    return p;
  endfunction

  // a^(2^m-2), zero maps to zero
  function automatic gf_t gf_inv(input gf_t a);
    gf_t r;
    r = 1;
    for (int i = 0; i < 2**`BCH_M-2; i++)
      r = gf_mul(r, a);
    return r;
  endfunction

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the BCH decoder testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal --top-module tb_bch_decoder \
  -f tb.f -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "build or run failed, see build.log and sim.log"; exit 1; }

grep -q "^RESULT: PASS$" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed, see sim.log"; exit 1; }

// ==== tb.f ====
+incdir+logic
logic/gf_pkg.sv
logic/bch_stream_pkg.sv
logic/bch_syndrome_count.sv
logic/bch_frame_buffer.sv
logic/bch_berlekamp.sv
logic/bch_chien_correct.sv
logic/bch_decoder_top.sv
bench/tb_clock_gen.sv
bench/bch_checker.sv
bench/tb_bch_decoder.sv
